// File: verilog.f
source/isa_pkg.sv
source/useq_pkg.sv
source/opcode_decoder.sv
source/instr_decoder.sv
source/micro_rom.sv
source/decode_unit.sv
test/decode_unit_tb.sv

// File: Bender.yml
package:
  name: decode_unit

sources:
  - source/isa_pkg.sv
  - source/useq_pkg.sv
  - source/opcode_decoder.sv
  - source/instr_decoder.sv
  - source/micro_rom.sv
  - source/decode_unit.sv
  - target: test
    files:
      - test/decode_unit_tb.sv

// File: test/decode_unit_tb.sv
// decode stage testbench: decode table, routine stepping, block freeze,
// divide fault and interrupt entry checks
`timescale 1ns/10ps

module decode_unit_tb;
  import isa_pkg::*;
  import useq_pkg::*;

  localparam real period     = 4.0;
  localparam int  n_rows     = 26;
  localparam int  n_directed = 5;
  localparam int  max_len    = 6;
  // reset, then per test up to two routines plus setup cycles
  localparam real watchdog_ns = (10 + (n_rows + n_directed) * (2 * max_len + 10)) * period;

  typedef struct packed {
    logic [7:0]                  opcode;
    logic [7:0]                  modrm;
    logic                        rep;
    logic [2:0]                  sop;
    logic                        need_modrm;
    logic                        need_imm;
    logic                        imm_size;
    logic [3:0]                  src;
    logic [3:0]                  dst;
    logic [micro_addr_width-1:0] entry;
    logic [micro_addr_width-1:0] len;
  } row_t;

  logic                        clk;
  logic                        rst;
  logic [7:0]                  opcode;
  logic [7:0]                  modrm;
  logic                        rep;
  logic                        block;
  logic                        exec_st;
  logic                        div_exc;
  logic                        intr;
  logic                        ifl;
  logic [2:0]                  sop_l;
  logic                        need_modrm;
  logic                        need_off;
  logic                        need_imm;
  logic                        off_size;
  logic                        imm_size;
  logic [3:0]                  src;
  logic [3:0]                  dst;
  logic [3:0]                  base;
  logic [3:0]                  index;
  logic [1:0]                  seg;
  logic [2:0]                  f;
  logic [micro_addr_width-1:0] seq_addr;
  logic [micro_op_width-1:0]   micro_op;
  logic                        end_seq;
  logic                        ext_int;
  logic                        inta;

  row_t        rows[$];
  string       names[$];
  logic [15:0] lfsr_state;
  string       cur_test;
  int          errors;
  int          errs_at_start;
  int          tests;
  int          failed_tests;

  decode_unit decode_unit_inst (
    .clk(clk), .rst(rst), .opcode(opcode), .modrm(modrm), .rep(rep),
    .block(block), .exec_st(exec_st), .div_exc(div_exc), .intr(intr),
    .ifl(ifl), .sop_l(sop_l), .need_modrm(need_modrm), .need_off(need_off),
    .need_imm(need_imm), .off_size(off_size), .imm_size(imm_size),
    .src(src), .dst(dst), .base(base), .index(index), .seg(seg), .f(f),
    .seq_addr(seq_addr), .micro_op(micro_op), .end_seq(end_seq),
    .ext_int(ext_int), .inta(inta)
  );

  always #(period / 2) clk = ~clk;

  initial begin
    #(watchdog_ns);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("Some tests failed");
    $finish;
  end

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v[i] = lfsr_state[0];
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errs_at_start = errors;
    next_cycle();
  endtask

  task automatic end_test();
    tests++;
    if (errors == errs_at_start) begin
      $display("test %s ok", cur_test);
    end else begin
      failed_tests++;
      $display("test %s FAILED, %0d errors", cur_test, errors - errs_at_start);
    end
  endtask

  task automatic add_row(input string name, input logic [7:0] op, input logic [7:0] mr,
                         input logic rp, input logic [2:0] sop, input logic nm,
                         input logic ni, input logic isz, input logic [3:0] s,
                         input logic [3:0] d, input logic [6:0] ent, input logic [6:0] ln);
    row_t r;
    r = {op, mr, rp, sop, nm, ni, isz, s, d, ent, ln};
    rows.push_back(r);
    names.push_back(name);
  endtask

  // alu form with random modrm and override, direction bit picks the reg side
  task automatic add_alu_random(input logic [7:0] op);
    logic [7:0] mr;
    logic [7:0] ov;
    logic [3:0] rm_side;
    logic [3:0] reg_side;
    logic       mem;
    draw(8, mr);
    draw(3, ov);
    mem      = mr[7:6] != 2'b11;
    rm_side  = mem ? reg_none : {1'b0, mr[2:0]};
    reg_side = {1'b0, mr[5:3]};
    add_row($sformatf("alu %02h random", op), op, mr, 1'b0, ov[2] ? {1'b1, ov[1:0]} : sop_none,
            1'b1, 1'b0, 1'b0, op[1] ? rm_side : reg_side, op[1] ? reg_side : rm_side,
            mem ? ua_alu_rm : ua_alu_rr, mem ? len_alu_rm : len_alu_rr);
  endtask

  task automatic build_table();
    add_row("add r,r", 8'h01, 8'hc8, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_cx, reg_ax, ua_alu_rr, len_alu_rr);
    add_row("add r,[bx+si]", 8'h03, 8'h00, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_none, reg_ax, ua_alu_rm, len_alu_rm);
    add_row("sub [bp+di+d8],r", 8'h29, 8'h53, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_dx, reg_none, ua_alu_rm, len_alu_rm);
    add_row("cmp r,es:[d16]", 8'h3b, 8'h0e, 1'b0, 3'b100, 1'b1, 1'b0, 1'b0,
            reg_none, reg_cx, ua_alu_rm, len_alu_rm);
    add_row("and cs:[bp+d16],r", 8'h21, 8'hbe, 1'b0, 3'b101, 1'b1, 1'b0, 1'b0,
            reg_di, reg_none, ua_alu_rm, len_alu_rm);
    add_row("add r,imm8", 8'h83, 8'hc3, 1'b0, sop_none, 1'b1, 1'b1, 1'b0,
            reg_none, reg_bx, ua_alu_imm, len_alu_imm);
    add_row("sub m,imm16", 8'h81, 8'h6f, 1'b0, sop_none, 1'b1, 1'b1, 1'b1,
            reg_none, reg_none, ua_alu_imm, len_alu_imm);
    add_row("mov r,r", 8'h89, 8'hd9, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_bx, reg_cx, ua_mov_rr, len_mov_rr);
    add_row("mov r,[bp+d8]", 8'h8b, 8'h46, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_none, reg_ax, ua_mov_rm, len_mov_rm);
    add_row("mov dx,imm16", 8'hba, 8'h00, 1'b0, sop_none, 1'b0, 1'b1, 1'b1,
            reg_none, reg_dx, ua_mov_imm, len_mov_imm);
    add_row("inc si", 8'h46, 8'h00, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_si, reg_si, ua_incdec, len_incdec);
    add_row("dec di", 8'h4f, 8'h00, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_di, reg_di, ua_incdec, len_incdec);
    add_row("push bp", 8'h55, 8'h00, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_bp, reg_none, ua_push, len_push);
    add_row("pop sp", 8'h5c, 8'h00, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_none, reg_sp, ua_pop, len_pop);
    add_row("nop", 8'h90, 8'h00, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_none, reg_none, ua_nop, len_nop);
    add_row("div bx", 8'hf7, 8'hf3, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_bx, reg_ax, ua_div, len_div);
    add_row("idiv [bx]", 8'hf7, 8'h3f, 1'b0, sop_none, 1'b1, 1'b0, 1'b0,
            reg_none, reg_ax, ua_div, len_div);
    // group f7 test form is outside the subset
    add_row("test invalid", 8'hf7, 8'hc0, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_none, reg_none, ua_invalid, len_invalid);
    add_row("ret invalid", 8'hc3, 8'h00, 1'b0, sop_none, 1'b0, 1'b0, 1'b0,
            reg_none, reg_none, ua_invalid, len_invalid);
    add_row("rep movsb", 8'ha4, 8'h00, 1'b1, sop_none, 1'b0, 1'b0, 1'b0,
            reg_none, reg_none, ua_invalid, len_invalid);
    add_alu_random(8'h01);
    add_alu_random(8'h03);
    add_alu_random(8'h28);
    add_alu_random(8'h2b);
    add_alu_random(8'h31);
    add_alu_random(8'h3a);
  endtask

  task automatic set_instr(input logic [7:0] op, input logic [7:0] mr, input logic rp,
                           input logic [2:0] sop);
    opcode = op;
    modrm  = mr;
    rep    = rp;
    sop_l  = sop;
  endtask

  // 16-bit effective address rules for the memory side of modrm
  task automatic check_decode(input row_t r);
    logic       mem_op;
    logic       direct;
    logic [3:0] eb;
    logic [3:0] ei;
    logic [1:0] es;
    mem_op = r.need_modrm && r.modrm[7:6] != 2'b11;
    direct = r.modrm[7:6] == 2'b00 && r.modrm[2:0] == 3'd6;
    case (r.modrm[2:0])
      3'd0: {eb, ei} = {reg_bx, reg_si};
      3'd1: {eb, ei} = {reg_bx, reg_di};
      3'd2: {eb, ei} = {reg_bp, reg_si};
      3'd3: {eb, ei} = {reg_bp, reg_di};
      3'd4: {eb, ei} = {reg_si, reg_none};
      3'd5: {eb, ei} = {reg_di, reg_none};
      3'd6: {eb, ei} = {direct ? reg_none : reg_bp, reg_none};
      default: {eb, ei} = {reg_bx, reg_none};
    endcase
    if (!mem_op)
      {eb, ei} = {reg_none, reg_none};
    es = (r.sop != sop_none) ? r.sop[1:0] : ((eb == reg_bp) ? seg_ss : seg_ds);
    check("need_modrm", r.need_modrm, need_modrm);
    check("need_off", mem_op && (r.modrm[7:6] inside {2'b01, 2'b10} || direct), need_off);
    check("off_size", mem_op && (r.modrm[7:6] == 2'b10 || direct), off_size);
    check("need_imm", r.need_imm, need_imm);
    check("imm_size", r.imm_size, imm_size);
    check("src", r.src, src);
    check("dst", r.dst, dst);
    check("base", eb, base);
    check("index", ei, index);
    // segment only matters with a memory operand
    if (mem_op)
      check("seg", es, seg);
    // group opcodes take the extension field, alu forms their own bits 5:3
    if (r.opcode inside {[8'h80:8'h83], 8'hf7})
      check("f", r.modrm[5:3], f);
    else if (r.opcode[7:6] == 2'b00)
      check("f", r.opcode[5:3], f);
  endtask

  // walk a routine from offset k0 until the end word, then one more edge
  task automatic run_routine(input int entry, input int len, input int k0);
    int k;
    bit done;
    k = k0;
    done = 0;
    exec_st = 1'b1;
    while (!done && k < 16) begin
      #1;
      check("seq_addr", entry + k, seq_addr);
      check("step", k, micro_op[3:0]);
      check("uop addr", entry + k, micro_op[uop_addr_lsb +: micro_addr_width]);
      if (end_seq)
        done = 1;
      else begin
        next_cycle();
        k++;
      end
    end
    assert (done) else begin
      $display("%s: routine at %0h never reached its end word", cur_test, entry);
      errors++;
    end
    if (done)
      check("length", len, k + 1);
    next_cycle();
    exec_st = 1'b0;
  endtask

  task automatic run_row(input int i);
    row_t r;
    r = rows[i];
    start_test(names[i]);
    set_instr(r.opcode, r.modrm, r.rep, r.sop);
    #1;
    check_decode(r);
    check("entry", r.entry, seq_addr);
    next_cycle();
    run_routine(r.entry, r.len, 0);
    #1;
    check("seq_addr after end", r.entry, seq_addr);
    end_test();
  endtask

  task automatic block_test();
    logic [micro_addr_width-1:0] held_addr;
    logic [micro_op_width-1:0]   held_op;
    start_test("block freeze");
    set_instr(8'h03, 8'h00, 1'b0, sop_none);
    next_cycle();
    exec_st = 1'b1;
    next_cycle();
    next_cycle();
    // freeze at offset 2
    block = 1'b1;
    #1;
    held_addr = seq_addr;
    held_op   = micro_op;
    check("seq_addr at block", ua_alu_rm + 2, held_addr);
    repeat (3) begin
      next_cycle();
      #1;
      check("held seq_addr", held_addr, seq_addr);
      check("held micro_op", held_op, micro_op);
    end
    next_cycle();
    block = 1'b0;
    run_routine(ua_alu_rm, len_alu_rm, 2);
    end_test();
  endtask

  task automatic div_fault_test();
    start_test("div fault");
    set_instr(8'hf7, 8'hf3, 1'b0, sop_none);
    div_exc = 1'b1;
    #1;
    check("seq_addr before fault", ua_div, seq_addr);
    next_cycle();
    div_exc = 1'b0;
    #1;
    check("fault entry", ua_intd, seq_addr);
    next_cycle();
    run_routine(ua_intd, len_intd, 0);
    #1;
    check("entry after handler", ua_div, seq_addr);
    end_test();
  endtask

  task automatic interrupt_test(input logic rp);
    logic [micro_addr_width-1:0] ient;
    logic [micro_addr_width-1:0] ilen;
    ient = rp ? ua_eintp : ua_eint;
    ilen = rp ? len_eintp : len_eint;
    start_test(rp ? "interrupt in rep" : "interrupt");
    set_instr(8'h90, 8'h00, rp, sop_none);
    intr = 1'b1;
    ifl  = 1'b1;
    next_cycle();
    run_routine(ua_nop, len_nop, 0);
    intr = 1'b0;
    #1;
    check("ext_int", 1, ext_int);
    check("inta early", 0, inta);
    check("interrupt entry", ient, seq_addr);
    // acknowledge trails ext_int by one edge
    next_cycle();
    #1;
    check("inta pulse", 1, inta);
    next_cycle();
    #1;
    check("inta after pulse", 0, inta);
    check("ext_int held", 1, ext_int);
    next_cycle();
    run_routine(ient, ilen, 0);
    #1;
    check("ext_int cleared", 0, ext_int);
    check("entry after interrupt", ua_nop, seq_addr);
    end_test();
  endtask

  task automatic masked_test();
    start_test("ifl low");
    set_instr(8'h90, 8'h00, 1'b0, sop_none);
    intr = 1'b1;
    ifl  = 1'b0;
    next_cycle();
    run_routine(ua_nop, len_nop, 0);
    #1;
    check("ext_int", 0, ext_int);
    check("seq_addr", ua_nop, seq_addr);
    next_cycle();
    intr = 1'b0;
    ifl  = 1'b1;
    #1;
    check("inta", 0, inta);
    end_test();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    block = 1'b0;
    exec_st = 1'b0;
    div_exc = 1'b0;
    intr = 1'b0;
    ifl = 1'b1;
    set_instr(8'h90, 8'h00, 1'b0, sop_none);
    errors = 0;
    tests = 0;
    failed_tests = 0;
    lfsr_state = 16'd51576;
    build_table();
    repeat (10) @(posedge clk);
    #0.5;
    rst = 1'b0;
    for (int i = 0; i < rows.size(); i++)
      run_row(i);
    block_test();
    div_fault_test();
    interrupt_test(1'b0);
    interrupt_test(1'b1);
    masked_test();
    $display("%0d tests, %0d failing, %0d check errors", tests, failed_tests, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: source/decode_unit.sv
// decode stage top: sequencing decoder and microcode store
`timescale 1ns/10ps

module decode_unit (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [7:0]                            opcode,
  input  logic [7:0]                            modrm,
  input  logic                                  rep,
  input  logic                                  block,
  input  logic                                  exec_st,
  input  logic                                  div_exc,
  input  logic                                  intr,
  input  logic                                  ifl,
  input  logic [2:0]                            sop_l,
  output logic                                  need_modrm,
  output logic                                  need_off,
  output logic                                  need_imm,
  output logic                                  off_size,
  output logic                                  imm_size,
  output logic [3:0]                            src,
  output logic [3:0]                            dst,
  output logic [3:0]                            base,
  output logic [3:0]                            index,
  output logic [1:0]                            seg,
  output logic [2:0]                            f,
  output logic [useq_pkg::micro_addr_width-1:0] seq_addr,
  output logic [useq_pkg::micro_op_width-1:0]   micro_op,
  output logic                                  end_seq,
  output logic                                  ext_int,
  output logic                                  inta
);

  instr_decoder instr_decoder_inst (
    .clk        (clk),
    .rst        (rst),
    .opcode     (opcode),
    .modrm      (modrm),
    .rep        (rep),
    .block      (block),
    .exec_st    (exec_st),
    .div_exc    (div_exc),
    .intr       (intr),
    .ifl        (ifl),
    .sop_l      (sop_l),
    .end_seq    (end_seq),
    .need_modrm (need_modrm),
    .need_off   (need_off),
    .need_imm   (need_imm),
    .off_size   (off_size),
    .imm_size   (imm_size),
    .src        (src),
    .dst        (dst),
    .base       (base),
    .index      (index),
    .seg        (seg),
    .f          (f),
    .seq_addr   (seq_addr),
    .ext_int    (ext_int),
    .inta       (inta)
  );

  // end bit closes the sequencing loop
  micro_rom micro_rom_inst (
    .seq_addr (seq_addr),
    .micro_op (micro_op),
    .end_seq  (end_seq)
  );

endmodule

// File: source/micro_rom.sv
// asynchronous microcode store, one tagged word per routine step
`timescale 1ns/10ps

module micro_rom (
  input  logic [useq_pkg::micro_addr_width-1:0] seq_addr,
  output logic [useq_pkg::micro_op_width-1:0]   micro_op,
  output logic                                  end_seq
);
  import useq_pkg::*;

  // builds the word for address addr inside a routine at entry
  function automatic logic [micro_op_width-1:0] uword(
    input logic [micro_addr_width-1:0] addr,
    input logic [uop_tag_width-1:0]    tag,
    input logic [micro_addr_width-1:0] entry,
    input logic [micro_addr_width-1:0] len
  );
    logic [micro_addr_width-1:0] step;
    logic [micro_op_width-1:0]   w;
    step = addr - entry;
    w = '0;
    w[uop_step_lsb +: uop_step_width]  = step[uop_step_width-1:0];
    w[uop_tag_lsb +: uop_tag_width]    = tag;
    w[uop_addr_lsb +: micro_addr_width] = addr;
    // last word of the routine
    w[uop_end_bit] = step == len - 1'b1;
    return w;
  endfunction

  always_comb begin
    case (seq_addr) inside
      [ua_alu_rr  : ua_alu_rr  + len_alu_rr  - 1]:
        micro_op = uword(seq_addr, 4'd0, ua_alu_rr, len_alu_rr);
      [ua_alu_rm  : ua_alu_rm  + len_alu_rm  - 1]:
        micro_op = uword(seq_addr, 4'd1, ua_alu_rm, len_alu_rm);
      [ua_alu_imm : ua_alu_imm + len_alu_imm - 1]:
        micro_op = uword(seq_addr, 4'd2, ua_alu_imm, len_alu_imm);
      [ua_mov_rr  : ua_mov_rr  + len_mov_rr  - 1]:
        micro_op = uword(seq_addr, 4'd3, ua_mov_rr, len_mov_rr);
      [ua_mov_rm  : ua_mov_rm  + len_mov_rm  - 1]:
        micro_op = uword(seq_addr, 4'd4, ua_mov_rm, len_mov_rm);
      [ua_mov_imm : ua_mov_imm + len_mov_imm - 1]:
        micro_op = uword(seq_addr, 4'd5, ua_mov_imm, len_mov_imm);
      [ua_incdec  : ua_incdec  + len_incdec  - 1]:
        micro_op = uword(seq_addr, 4'd6, ua_incdec, len_incdec);
      [ua_push    : ua_push    + len_push    - 1]:
        micro_op = uword(seq_addr, 4'd7, ua_push, len_push);
      [ua_pop     : ua_pop     + len_pop     - 1]:
        micro_op = uword(seq_addr, 4'd8, ua_pop, len_pop);
      [ua_nop     : ua_nop     + len_nop     - 1]:
        micro_op = uword(seq_addr, 4'd9, ua_nop, len_nop);
      [ua_div     : ua_div     + len_div     - 1]:
        micro_op = uword(seq_addr, 4'd10, ua_div, len_div);
      [ua_invalid : ua_invalid + len_invalid - 1]:
        micro_op = uword(seq_addr, 4'd11, ua_invalid, len_invalid);
      [ua_intd    : ua_intd    + len_intd    - 1]:
        micro_op = uword(seq_addr, 4'd12, ua_intd, len_intd);
      [ua_eint    : ua_eint    + len_eint    - 1]:
        micro_op = uword(seq_addr, 4'd13, ua_eint, len_eint);
      [ua_eintp   : ua_eintp   + len_eintp   - 1]:
        micro_op = uword(seq_addr, 4'd14, ua_eintp, len_eintp);
      // unused space ends at once so the counter cannot run away
      default: micro_op = uword(seq_addr, 4'd15, seq_addr, 7'd1);
    endcase
  end

  assign end_seq = micro_op[uop_end_bit];

endmodule

// File: source/instr_decoder.sv
// microcode sequencing: step counter, divide fault and interrupt state,
// interrupt acknowledge
`timescale 1ns/10ps

module instr_decoder (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [7:0]                            opcode,
  input  isa_pkg::modrm_u                       modrm,
  input  logic                                  rep,
  input  logic                                  block,
  input  logic                                  exec_st,
  input  logic                                  div_exc,
  input  logic                                  intr,
  input  logic                                  ifl,
  input  logic [2:0]                            sop_l,
  input  logic                                  end_seq,
  output logic                                  need_modrm,
  output logic                                  need_off,
  output logic                                  need_imm,
  output logic                                  off_size,
  output logic                                  imm_size,
  output logic [3:0]                            src,
  output logic [3:0]                            dst,
  output logic [3:0]                            base,
  output logic [3:0]                            index,
  output logic [1:0]                            seg,
  output logic [2:0]                            f,
  output logic [useq_pkg::micro_addr_width-1:0] seq_addr,
  output logic                                  ext_int,
  output logic                                  inta
);
  import useq_pkg::*;

  logic [micro_addr_width-1:0] base_addr;
  logic [micro_addr_width-1:0] entry;
  logic [micro_addr_width-1:0] seq;
  logic                        dive;
  logic                        old_ext_int;

  opcode_decoder opcode_decoder_inst (
    .opcode     (opcode),
    .modrm      (modrm),
    .rep        (rep),
    .sop_l      (sop_l),
    .base_addr  (base_addr),
    .need_modrm (need_modrm),
    .need_off   (need_off),
    .need_imm   (need_imm),
    .off_size   (off_size),
    .imm_size   (imm_size),
    .src        (src),
    .dst        (dst),
    .base       (base),
    .index      (index),
    .seg        (seg)
  );

  // divide fault beats interrupt beats the decoded routine
  assign entry    = dive ? ua_intd : (ext_int ? (rep ? ua_eintp : ua_eint) : base_addr);
  assign seq_addr = entry + seq;

  // group opcodes take their function from the opext field
  assign f = opcode[7] ? modrm.ext.opext : opcode[5:3];

  always_ff @(posedge clk) begin
    if (rst) begin
      seq     <= '0;
      dive    <= 1'b0;
      ext_int <= 1'b0;
    end else if (!block) begin
      // step through the routine, back to 0 after its last word
      seq     <= (exec_st && !end_seq) ? seq + 1'b1 : '0;
      dive    <= div_exc || (dive && !end_seq);
      // interrupts only at an instruction boundary
      ext_int <= (intr && ifl && exec_st && end_seq) || (ext_int && !end_seq);
    end
  end

  // acknowledge on the rising edge of ext_int
  always_ff @(posedge clk) begin
    if (rst) begin
      old_ext_int <= 1'b0;
      inta        <= 1'b0;
    end else begin
      old_ext_int <= ext_int;
      inta        <= ext_int && !old_ext_int;
    end
  end

endmodule

// File: source/opcode_decoder.sv
// opcode and modrm classification into operand needs, register and
// segment selectors and the microcode entry
`timescale 1ns/10ps

module opcode_decoder (
  input  logic [7:0]                            opcode,
  input  isa_pkg::modrm_u                       modrm,
  input  logic                                  rep,
  input  logic [2:0]                            sop_l,
  output logic [useq_pkg::micro_addr_width-1:0] base_addr,
  output logic                                  need_modrm,
  output logic                                  need_off,
  output logic                                  need_imm,
  output logic                                  off_size,
  output logic                                  imm_size,
  output logic [3:0]                            src,
  output logic [3:0]                            dst,
  output logic [3:0]                            base,
  output logic [3:0]                            index,
  output logic [1:0]                            seg
);
  import isa_pkg::*;
  import useq_pkg::*;

  logic [3:0] cls;
  logic       mem;
  logic       direct;
  logic       d;
  logic [3:0] reg_r;
  logic [3:0] reg_m;
  logic [3:0] reg_o;
  logic [3:0] ea_base;
  logic [3:0] ea_index;
  logic [1:0] def_seg;

  assign mem    = modrm.ops.mod != 2'b11;
  // mod 0 rm 6 is a bare 16-bit address
  assign direct = (modrm.ops.mod == 2'b00) && (modrm.ops.rm == 3'd6);
  // direction bit, reg field is the destination
  assign d      = opcode[1];
  assign reg_r  = {1'b0, modrm.ops.regf};
  assign reg_m  = mem ? reg_none : {1'b0, modrm.ops.rm};
  // register encoded in the opcode itself
  assign reg_o  = {1'b0, opcode[2:0]};

  always_comb begin
    cls = cls_invalid;
    if (opcode[7:6] == 2'b00 && !opcode[2])
      cls = cls_alu;
    else if (opcode[7:4] == 4'h4)
      cls = cls_incdec;
    else if (opcode[7:3] == 5'b01010)
      cls = cls_push;
    else if (opcode[7:3] == 5'b01011)
      cls = cls_pop;
    else if (opcode[7:2] == 6'b100000)
      cls = cls_alu_imm;
    else if (opcode[7:2] == 6'b100010)
      cls = cls_mov;
    else if (opcode == 8'h90)
      cls = cls_nop;
    else if (opcode[7:3] == 5'b10111)
      cls = cls_mov_imm;
    // only div (6) and idiv (7) of group f7
    else if (opcode == 8'hf7 && modrm.ext.opext[2:1] == 2'b11)
      cls = cls_div;
    // rep string forms have no routine in this subset
    if (rep && opcode inside {[8'ha4:8'haf]})
      cls = cls_invalid;
  end

  // effective address registers from rm
  always_comb begin
    case (modrm.ops.rm)
      3'd0:    {ea_base, ea_index} = {reg_bx, reg_si};
      3'd1:    {ea_base, ea_index} = {reg_bx, reg_di};
      3'd2:    {ea_base, ea_index} = {reg_bp, reg_si};
      3'd3:    {ea_base, ea_index} = {reg_bp, reg_di};
      3'd4:    {ea_base, ea_index} = {reg_si, reg_none};
      3'd5:    {ea_base, ea_index} = {reg_di, reg_none};
      3'd6:    {ea_base, ea_index} = {direct ? reg_none : reg_bp, reg_none};
      default: {ea_base, ea_index} = {reg_bx, reg_none};
    endcase
  end

  // bp based addressing defaults to ss
  assign def_seg = (ea_base == reg_bp) ? seg_ss : seg_ds;
  assign seg     = (sop_l != sop_none) ? sop_l[1:0] : def_seg;

  always_comb begin
    base_addr  = ua_invalid;
    need_modrm = 1'b0;
    need_imm   = 1'b0;
    imm_size   = 1'b0;
    src        = reg_none;
    dst        = reg_none;
    case (cls)
      cls_alu: begin
        base_addr  = mem ? ua_alu_rm : ua_alu_rr;
        need_modrm = 1'b1;
        src        = d ? reg_m : reg_r;
        dst        = d ? reg_r : reg_m;
      end
      cls_alu_imm: begin
        base_addr  = ua_alu_imm;
        need_modrm = 1'b1;
        need_imm   = 1'b1;
        // 81 carries a word, 80/82/83 a byte
        imm_size   = opcode[1:0] == 2'b01;
        dst        = reg_m;
      end
      cls_mov: begin
        base_addr  = mem ? ua_mov_rm : ua_mov_rr;
        need_modrm = 1'b1;
        src        = d ? reg_m : reg_r;
        dst        = d ? reg_r : reg_m;
      end
      cls_mov_imm: begin
        base_addr = ua_mov_imm;
        need_imm  = 1'b1;
        imm_size  = 1'b1;
        dst       = reg_o;
      end
      cls_incdec: begin
        base_addr = ua_incdec;
        src       = reg_o;
        dst       = reg_o;
      end
      cls_push: begin
        base_addr = ua_push;
        src       = reg_o;
      end
      cls_pop: begin
        base_addr = ua_pop;
        dst       = reg_o;
      end
      cls_nop:
        base_addr = ua_nop;
      cls_div: begin
        base_addr  = ua_div;
        need_modrm = 1'b1;
        // divisor from rm, quotient into ax
        src        = reg_m;
        dst        = reg_ax;
      end
      default:
        base_addr = ua_invalid;
    endcase
  end

  // displacement bytes only follow a memory modrm
  assign need_off = need_modrm && (modrm.ops.mod == 2'b01 || modrm.ops.mod == 2'b10 || direct);
  assign off_size = need_modrm && (modrm.ops.mod == 2'b10 || direct);
  assign base     = (need_modrm && mem) ? ea_base : reg_none;
  assign index    = (need_modrm && mem) ? ea_index : reg_none;

endmodule

// File: source/useq_pkg.sv
// microcode address space, routine entries and lengths, micro-op word layout
package useq_pkg;

  localparam int unsigned micro_addr_width = 7;
  localparam int unsigned micro_op_width   = 16;

  // routine entry points, packed back to back
  localparam logic [micro_addr_width-1:0] ua_alu_rr  = 7'd0;
  localparam logic [micro_addr_width-1:0] ua_alu_rm  = 7'd1;
  localparam logic [micro_addr_width-1:0] ua_alu_imm = 7'd5;
  localparam logic [micro_addr_width-1:0] ua_mov_rr  = 7'd8;
  localparam logic [micro_addr_width-1:0] ua_mov_rm  = 7'd9;
  localparam logic [micro_addr_width-1:0] ua_mov_imm = 7'd11;
  localparam logic [micro_addr_width-1:0] ua_incdec  = 7'd12;
  localparam logic [micro_addr_width-1:0] ua_push    = 7'd13;
  localparam logic [micro_addr_width-1:0] ua_pop     = 7'd15;
  localparam logic [micro_addr_width-1:0] ua_nop     = 7'd17;
  localparam logic [micro_addr_width-1:0] ua_div     = 7'd18;
  localparam logic [micro_addr_width-1:0] ua_invalid = 7'd24;
  // divide fault handler
  localparam logic [micro_addr_width-1:0] ua_intd    = 7'd27;
  // external interrupt, plain and inside a rep string
  localparam logic [micro_addr_width-1:0] ua_eint    = 7'd32;
  localparam logic [micro_addr_width-1:0] ua_eintp   = 7'd37;

  // routine lengths in words
  localparam logic [micro_addr_width-1:0] len_alu_rr  = 7'd1;
  localparam logic [micro_addr_width-1:0] len_alu_rm  = 7'd4;
  localparam logic [micro_addr_width-1:0] len_alu_imm = 7'd3;
  localparam logic [micro_addr_width-1:0] len_mov_rr  = 7'd1;
  localparam logic [micro_addr_width-1:0] len_mov_rm  = 7'd2;
  localparam logic [micro_addr_width-1:0] len_mov_imm = 7'd1;
  localparam logic [micro_addr_width-1:0] len_incdec  = 7'd1;
  localparam logic [micro_addr_width-1:0] len_push    = 7'd2;
  localparam logic [micro_addr_width-1:0] len_pop     = 7'd2;
  localparam logic [micro_addr_width-1:0] len_nop     = 7'd1;
  localparam logic [micro_addr_width-1:0] len_div     = 7'd6;
  localparam logic [micro_addr_width-1:0] len_invalid = 7'd3;
  localparam logic [micro_addr_width-1:0] len_intd    = 7'd5;
  localparam logic [micro_addr_width-1:0] len_eint    = 7'd5;
  localparam logic [micro_addr_width-1:0] len_eintp   = 7'd6;

  // word layout: end | address | tag | step
  localparam int unsigned uop_end_bit    = 15;
  localparam int unsigned uop_addr_lsb   = 8;
  localparam int unsigned uop_tag_lsb    = 4;
  localparam int unsigned uop_tag_width  = 4;
  localparam int unsigned uop_step_lsb   = 0;
  localparam int unsigned uop_step_width = 4;

endpackage

// File: source/isa_pkg.sv
// x86 instruction-set encodings: opcode classes, register and segment
// selectors, modrm byte views
package isa_pkg;

  // opcode classes out of the first decode step
  localparam logic [3:0] cls_invalid = 4'd0;
  localparam logic [3:0] cls_alu     = 4'd1;
  localparam logic [3:0] cls_alu_imm = 4'd2;
  localparam logic [3:0] cls_mov     = 4'd3;
  localparam logic [3:0] cls_mov_imm = 4'd4;
  localparam logic [3:0] cls_incdec  = 4'd5;
  localparam logic [3:0] cls_push    = 4'd6;
  localparam logic [3:0] cls_pop     = 4'd7;
  localparam logic [3:0] cls_nop     = 4'd8;
  localparam logic [3:0] cls_div     = 4'd9;

  // 16-bit register file numbers
  localparam logic [3:0] reg_ax   = 4'd0;
  localparam logic [3:0] reg_cx   = 4'd1;
  localparam logic [3:0] reg_dx   = 4'd2;
  localparam logic [3:0] reg_bx   = 4'd3;
  localparam logic [3:0] reg_sp   = 4'd4;
  localparam logic [3:0] reg_bp   = 4'd5;
  localparam logic [3:0] reg_si   = 4'd6;
  localparam logic [3:0] reg_di   = 4'd7;
  localparam logic [3:0] reg_none = 4'd8;

  localparam logic [1:0] seg_es = 2'd0;
  localparam logic [1:0] seg_cs = 2'd1;
  localparam logic [1:0] seg_ss = 2'd2;
  localparam logic [1:0] seg_ds = 2'd3;

  // override prefix comes in as {1, seg}; all zero when absent
  localparam logic [2:0] sop_none = 3'b000;

  // same byte, two readings: operand addressing or group extension
  typedef union packed {
    struct packed {
      logic [1:0] mod;
      logic [2:0] regf;
      logic [2:0] rm;
    } ops;
    struct packed {
      logic [1:0] mod;
      logic [2:0] opext;
      logic [2:0] rm;
    } ext;
  } modrm_u;

endpackage
